// File: source/usb_ctrl_params.svh
`ifndef USB_CTRL_PARAMS_SVH
`define USB_CTRL_PARAMS_SVH

`default_nettype none

// serial link frame, payload bits after the start bit
`define FRAME_BITS 16

// flops per synchronizer chain in the mailbox
`define SYNC_STAGES 2

// scratch memory size in bytes, indexed by one byte
`define SCRATCH_DEPTH 256

// first response byte of the echo command
`define ACK_TAG 8'h12

`default_nettype wire

`endif

// File: source/usb_ctrl_pkg.sv
`default_nettype none

package usb_ctrl_pkg;

  // one byte of frame payload
  typedef logic [7:0] byte_t;

  // host opcodes still decoded
  // anything else completes with no effect
  typedef enum logic [7:0] {
    OP_SET_ADDR = 8'h01,  // latch scratch address
    OP_WRITE    = 8'h02,  // write byte at latched address
    OP_READ     = 8'h03,  // reply with byte at operand address
    OP_ECHO     = 8'h30   // reply with ack tag and operand
  } opcode_e;

  // command frame payload
  // opcode goes out first on the wire
  typedef struct packed {
    byte_t opcode;
    byte_t operand;
  } cmd_word_t;

  // response frame payload, lo leaves first
  typedef struct packed {
    byte_t lo;
    byte_t hi;
  } rsp_word_t;

endpackage

`default_nettype wire

// File: source/host_msg_if.sv
`default_nettype none

// sys_clk side traffic between the mailboxes and the executor
interface host_msg_if;
  import usb_ctrl_pkg::*;

  logic      cmd_valid;  // one cycle, from command mailbox
  cmd_word_t cmd;        // stable while the mailbox is busy
  logic      rsp_load;   // one cycle, from executor
  rsp_word_t rsp;        // captured by response mailbox on rsp_load
  logic      rsp_busy;   // response still crossing or in flight

  // executor end
  modport exec (
    input  cmd_valid,
    input  cmd,
    input  rsp_busy,
    output rsp_load,
    output rsp
  );

  // mailbox end
  modport link (
    output cmd_valid,
    output cmd,
    output rsp_busy,
    input  rsp_load,
    input  rsp
  );

endinterface

`default_nettype wire

// File: source/cdc_mailbox.sv
`include "usb_ctrl_params.svh"
`default_nettype none

module cdc_mailbox #(
  parameter type payload_t = usb_ctrl_pkg::cmd_word_t
) (
  input  logic     src_clk,
  input  logic     dst_clk,
  input  logic     sys_rst_n,
  // source side
  input  logic     load,
  input  payload_t data,
  output logic     busy,
  // destination side
  output logic     valid,
  output payload_t q
);
  import usb_ctrl_pkg::*;

  payload_t               hold_q;    // source copy, untouched while busy
  logic                   req;       // src_clk level
  logic                   ack;       // dst_clk level
  logic [`SYNC_STAGES-1:0] req_sync; // req into dst_clk
  logic [`SYNC_STAGES-1:0] ack_sync; // ack back into src_clk
  logic                   req_s;
  logic                   ack_s;

  assign req_s = req_sync[`SYNC_STAGES-1];
  assign ack_s = ack_sync[`SYNC_STAGES-1];

  // payload capture
  always_ff @(posedge src_clk) begin
    if (load && !busy) begin
      hold_q <= data;
    end
  end

  // source handshake
  always_ff @(posedge src_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      req      <= 1'b0;
      busy     <= 1'b0;
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[`SYNC_STAGES-2:0], ack};
      if (load && !busy) begin  // load during busy just falls away
        req  <= 1'b1;
        busy <= 1'b1;
      end else if (req && ack_s) begin
        req <= 1'b0;            // phase 3
      end else if (busy && !req && !ack_s) begin
        busy <= 1'b0;           // ack gone so phase 4 is done
      end
    end
  end

  // destination handshake
  always_ff @(posedge dst_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      req_sync <= '0;
      ack      <= 1'b0;
      valid    <= 1'b0;
    end else begin
      req_sync <= {req_sync[`SYNC_STAGES-2:0], req};
      valid    <= 1'b0;
      if (req_s && !ack) begin
        ack   <= 1'b1;  // phase 2
        valid <= 1'b1;  // single pulse per transfer
      end else if (!req_s && ack) begin
        ack <= 1'b0;
      end
    end
  end

  // hold_q settled long before req_s rises
  assign q = hold_q;

endmodule

`default_nettype wire

// File: source/cmd_deserializer.sv
`include "usb_ctrl_params.svh"
`default_nettype none

module cmd_deserializer (
  input  logic                    link_clk,
  input  logic                    sys_rst_n,
  input  logic                    link_rx,
  output usb_ctrl_pkg::cmd_word_t word,
  output logic                    load,
  input  logic                    mbox_busy
);
  import usb_ctrl_pkg::*;

  logic [4:0]             bit_cnt;  // 0 waits for start, then bit index 1..16
  logic [`FRAME_BITS-1:0] shift_q;  // first bit settles at bit 0

  // frame control
  always_ff @(posedge link_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt <= '0;
      load    <= 1'b0;
    end else begin
      load <= 1'b0;
      if (bit_cnt == '0) begin
        if (link_rx) begin
          bit_cnt <= 5'd1;  // start bit seen
        end
      end else if (bit_cnt == 5'(`FRAME_BITS)) begin
        bit_cnt <= '0;
        // mailbox still busy so this frame is lost
        load    <= !mbox_busy;
      end else begin
        bit_cnt <= bit_cnt + 5'd1;
      end
    end
  end

  // LSB first shifter
  // holds until the next start bit, long after the mailbox captured it
  always_ff @(posedge link_clk) begin
    if (bit_cnt != '0) begin
      shift_q <= {link_rx, shift_q[`FRAME_BITS-1:1]};
    end
  end

  assign word = cmd_word_t'{
    opcode:  shift_q[7:0],   // first byte on the wire
    operand: shift_q[15:8]
  };

endmodule

`default_nettype wire

// File: source/rsp_serializer.sv
`include "usb_ctrl_params.svh"
`default_nettype none

module rsp_serializer (
  input  logic                    link_clk,
  input  logic                    sys_rst_n,
  input  usb_ctrl_pkg::rsp_word_t word,
  input  logic                    start,
  output logic                    link_tx
);
  import usb_ctrl_pkg::*;

  logic                   active;   // frame in flight
  logic [4:0]             bit_cnt;  // data bits already sent
  logic [`FRAME_BITS-1:0] shift_q;  // lo in the low byte goes out first

  // control and line driver
  always_ff @(posedge link_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      active  <= 1'b0;
      bit_cnt <= '0;
      link_tx <= 1'b0;
    end else if (!active) begin
      link_tx <= 1'b0;
      if (start) begin
        active  <= 1'b1;
        bit_cnt <= '0;
        link_tx <= 1'b1;  // start bit
      end
    end else if (bit_cnt == 5'(`FRAME_BITS)) begin
      active  <= 1'b0;
      link_tx <= 1'b0;    // stop level
    end else begin
      bit_cnt <= bit_cnt + 5'd1;
      link_tx <= shift_q[0];
    end
  end

  // data path ignores start mid frame
  always_ff @(posedge link_clk) begin
    if (!active && start) begin
      shift_q <= {word.hi, word.lo};
    end else if (active) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

// File: source/cmd_executor.sv
`include "usb_ctrl_params.svh"
`default_nettype none

module cmd_executor (
  input  logic            sys_clk,
  input  logic            sys_rst_n,
  host_msg_if.exec        msg,
  output logic            busy
);
  import usb_ctrl_pkg::*;

  cmd_word_t cur_q;                       // command being run
  opcode_e   op;
  byte_t     addr_q;                      // scratch pointer for OP_WRITE
  byte_t     scratch [`SCRATCH_DEPTH];
  logic      needs_rsp;
  logic      done;

  assign op        = opcode_e'(cur_q.opcode);
  assign needs_rsp = (op == OP_READ) || (op == OP_ECHO);
  // responses hold off until the response mailbox is free
  assign done      = busy && !(needs_rsp && msg.rsp_busy);

  // control
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      busy         <= 1'b0;
      addr_q       <= '0;
      msg.rsp_load <= 1'b0;
    end else begin
      msg.rsp_load <= 1'b0;
      if (!busy) begin
        // a command arriving while busy is dropped
        if (msg.cmd_valid) begin
          busy <= 1'b1;
        end
      end else if (done) begin
        busy         <= 1'b0;
        msg.rsp_load <= needs_rsp;
        if (op == OP_SET_ADDR) begin
          addr_q <= cur_q.operand;
        end
      end
    end
  end

  // command latch, scratch memory and response payload
  always_ff @(posedge sys_clk) begin
    if (!busy && msg.cmd_valid) begin
      cur_q <= msg.cmd;
    end
    if (done) begin
      case (op)
        OP_WRITE: begin
          scratch[addr_q] <= cur_q.operand;  // no auto increment
        end
        OP_READ: begin
          msg.rsp <= '{lo: scratch[cur_q.operand], hi: 8'h00};
        end
        OP_ECHO: begin
          msg.rsp <= '{lo: `ACK_TAG, hi: cur_q.operand};
        end
        default: begin
          // set address lives in the control block
          // unknown opcodes do nothing
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/usb_ctrl_top.sv
`default_nettype none

module usb_ctrl_top (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic link_clk,   // host bit clock
  input  logic link_rx,    // host to chip
  output logic link_tx,    // chip to host
  output logic busy
);
  import usb_ctrl_pkg::*;

  // link_clk domain
  cmd_word_t cmd_word;
  logic      cmd_load;
  logic      cmd_mbox_busy;
  rsp_word_t rsp_word;
  logic      rsp_start;

  // sys_clk domain bundle
  host_msg_if msg_if ();

  cmd_deserializer cmd_rx_i (
    .link_clk  (link_clk),
    .sys_rst_n (sys_rst_n),
    .link_rx   (link_rx),
    .word      (cmd_word),
    .load      (cmd_load),
    .mbox_busy (cmd_mbox_busy)
  );

  // link_clk to sys_clk
  cdc_mailbox #(.payload_t(cmd_word_t)) cmd_mbox_i (
    .src_clk   (link_clk),
    .dst_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .load      (cmd_load),
    .data      (cmd_word),
    .busy      (cmd_mbox_busy),
    .valid     (msg_if.cmd_valid),
    .q         (msg_if.cmd)
  );

  cmd_executor exec_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .msg       (msg_if.exec),
    .busy      (busy)
  );

  // sys_clk to link_clk, busy doubles as executor back pressure
  cdc_mailbox #(.payload_t(rsp_word_t)) rsp_mbox_i (
    .src_clk   (sys_clk),
    .dst_clk   (link_clk),
    .sys_rst_n (sys_rst_n),
    .load      (msg_if.rsp_load),
    .data      (msg_if.rsp),
    .busy      (msg_if.rsp_busy),
    .valid     (rsp_start),
    .q         (rsp_word)
  );

  rsp_serializer rsp_tx_i (
    .link_clk  (link_clk),
    .sys_rst_n (sys_rst_n),
    .word      (rsp_word),
    .start     (rsp_start),
    .link_tx   (link_tx)
  );

endmodule

`default_nettype wire

// File: dv/usb_ctrl_props.sv
`default_nettype none

// handshake checks for one cdc_mailbox instance
module usb_ctrl_props (
  input logic src_clk,
  input logic dst_clk,
  input logic sys_rst_n,
  input logic req,
  input logic ack_s,   // ack after the src_clk synchronizer
  input logic busy,
  input logic valid
);

  localparam int BUSY_MAX = 64;  // src cycles, a round trip needs far fewer

  int busy_cyc;  // src cycles in the current busy stretch

  always_ff @(posedge src_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      busy_cyc <= 0;
    end else if (busy) begin
      busy_cyc <= busy_cyc + 1;
    end else begin
      busy_cyc <= 0;
    end
  end

  // request stays up until the synced ack returns
  req_held_a: assert property (
    @(posedge src_clk) disable iff (!sys_rst_n) (req && !ack_s) |=> req
  ) else $error("mailbox request fell before its acknowledge");

  // source busy covers the whole request phase
  req_busy_a: assert property (
    @(posedge src_clk) disable iff (!sys_rst_n) req |-> busy
  ) else $error("mailbox request raised without busy");

  // one valid per transfer
  valid_pulse_a: assert property (
    @(posedge dst_clk) disable iff (!sys_rst_n) valid |=> !valid
  ) else $error("mailbox valid held longer than one cycle");

  // busy drops again within a bounded time
  busy_bounded_a: assert property (
    @(posedge src_clk) disable iff (!sys_rst_n) busy_cyc < BUSY_MAX
  ) else $error("mailbox busy stuck high");

endmodule

`default_nettype wire

// File: dv/usb_ctrl_tb.sv
`include "usb_ctrl_params.svh"
`default_nettype none

module usb_ctrl_tb;
  import usb_ctrl_pkg::*;

  localparam int SYS_HALF   = 10;
  localparam int LINK_HALF  = 30;
  localparam int RST_CYCLES = 16;
  localparam int N_FRAMES   = 40;                      // commands over all tests rounded up
  localparam int FRAME_CYC  = 4 * (`FRAME_BITS + 2);   // link cycles per command with slack
  localparam int RSP_WAIT   = 3 * (`FRAME_BITS + 2);   // link cycles to wait for a start bit
  localparam int BUSY_WAIT  = 20 * (`FRAME_BITS + 2);  // sys cycles for the busy pulse
  localparam int WATCHDOG_T = 2 * (RST_CYCLES * 2 * SYS_HALF
                                   + N_FRAMES * FRAME_CYC * 2 * LINK_HALF);

  logic   sys_clk;
  logic   sys_rst_n;
  logic   link_clk;
  logic   link_rx;
  logic   link_tx;
  logic   busy;
  int     errors = 0;
  integer seed = 79460;
  byte_t  model [`SCRATCH_DEPTH];  // expected scratch bytes

  usb_ctrl_top dut_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .link_clk  (link_clk),
    .link_rx   (link_rx),
    .link_tx   (link_tx),
    .busy      (busy)
  );

  // both mailboxes get the handshake checks
  bind cdc_mailbox usb_ctrl_props props_i (
    .src_clk   (src_clk),
    .dst_clk   (dst_clk),
    .sys_rst_n (sys_rst_n),
    .req       (req),
    .ack_s     (ack_s),
    .busy      (busy),
    .valid     (valid)
  );

  initial begin
    sys_clk = 1'b0;
    forever #SYS_HALF sys_clk = ~sys_clk;
  end

  // offset so link edges never meet sys edges
  initial begin
    link_clk = 1'b0;
    #5;
    forever #LINK_HALF link_clk = ~link_clk;
  end

  task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // host end of the command link sends the opcode LSB first
  task automatic send_cmd(input byte_t opcode, input byte_t operand);
    logic [`FRAME_BITS-1:0] bits;
    int waited;
    bits = {operand, opcode};
    waited = 0;
    @(posedge link_clk);
    link_rx <= 1'b1;  // start bit
    for (int i = 0; i < `FRAME_BITS; i++) begin
      @(posedge link_clk);
      link_rx <= bits[i];
    end
    @(posedge link_clk);
    link_rx <= 1'b0;
    while (!busy && waited < BUSY_WAIT) begin  // frame still crossing
      @(negedge sys_clk);
      waited++;
    end
    while (busy && waited < BUSY_WAIT) begin   // may stretch while a response waits
      @(negedge sys_clk);
      waited++;
    end
    if (waited >= BUSY_WAIT) begin
      errors++;
      $display("%0t: no busy pulse came back for command %h %h", $time, opcode, operand);
    end
  endtask

  // bounded wait for a start bit then 16 bits and the stop level
  task automatic recv_rsp(input bit want, input rsp_word_t exp, input string what);
    logic [`FRAME_BITS-1:0] bits;
    int waited;
    waited = 0;
    @(negedge link_clk);
    while (!link_tx && waited < RSP_WAIT) begin
      @(negedge link_clk);
      waited++;
    end
    check(16'(link_tx), 16'(want), {what, " frame present"});
    if (link_tx) begin
      for (int i = 0; i < `FRAME_BITS; i++) begin
        @(negedge link_clk);
        bits[i] = link_tx;
      end
      @(negedge link_clk);
      check(16'(link_tx), 16'h0000, {what, " stop level"});
      if (want) begin
        check(bits, {exp.hi, exp.lo}, what);  // lo arrived first
      end
    end
  endtask

  task automatic echo_once(input byte_t operand);
    send_cmd(OP_ECHO, operand);
    recv_rsp(1'b1, rsp_word_t'{lo: `ACK_TAG, hi: operand}, "echo");
  endtask

  task automatic read_back(input byte_t addr);
    send_cmd(OP_READ, addr);
    recv_rsp(1'b1, rsp_word_t'{lo: model[addr], hi: 8'h00}, $sformatf("read of %h", addr));
  endtask

  task automatic idle_after_reset();
    check(16'(link_tx), 16'h0000, "link_tx after reset");
    check(16'(busy), 16'h0000, "busy after reset");
    recv_rsp(1'b0, '0, "idle link");
  endtask

  // model keeps the last write on an address collision
  task automatic scratch_write_read();
    byte_t addrs [8];
    byte_t val;
    foreach (addrs[i]) begin
      addrs[i] = byte_t'($random(seed));
      val = byte_t'($random(seed));
      send_cmd(OP_SET_ADDR, addrs[i]);
      send_cmd(OP_WRITE, val);
      model[addrs[i]] = val;
    end
    foreach (addrs[i]) begin
      read_back(addrs[i]);
    end
  endtask

  // second write hits the same byte with no auto increment
  task automatic addr_persistence();
    byte_t addr;
    byte_t val;
    addr = byte_t'($random(seed));
    val = byte_t'($random(seed));
    send_cmd(OP_SET_ADDR, addr);
    send_cmd(OP_WRITE, val);
    send_cmd(OP_WRITE, ~val);
    model[addr] = ~val;
    read_back(addr);
  endtask

  task automatic unknown_opcodes();
    send_cmd(8'h00, byte_t'($random(seed)));
    recv_rsp(1'b0, '0, "opcode 00");
    send_cmd(8'h55, byte_t'($random(seed)));
    recv_rsp(1'b0, '0, "opcode 55");
    echo_once(byte_t'($random(seed)));  // link still alive
  endtask

  initial begin
    sys_rst_n = 1'b0;
    link_rx = 1'b0;
    repeat (RST_CYCLES) @(posedge sys_clk);
    sys_rst_n <= 1'b1;
    @(negedge sys_clk);
    idle_after_reset();
    repeat (8) begin
      echo_once(byte_t'($random(seed)));
    end
    scratch_write_read();
    addr_persistence();
    unknown_opcodes();
    $display("tests done, %0d error(s)", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #WATCHDOG_T;
    $display("timeout: tests still running at %0t, run stopped", $time);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/usb_ctrl_pkg.sv
source/host_msg_if.sv
source/cdc_mailbox.sv
source/cmd_deserializer.sv
source/rsp_serializer.sv
source/cmd_executor.sv
source/usb_ctrl_top.sv
dv/usb_ctrl_props.sv
dv/usb_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usb_ctrl_tb -f list.f -o usb_ctrl_sim \
  || { echo "build error"; exit 1; }
./obj_dir/usb_ctrl_sim > sim.log 2>&1
sim_status=$?
cat sim.log
[ "$sim_status" -eq 0 ] && ! grep -qF '*** FAILED ***' sim.log \
  && echo "run ok" || { echo "run failed"; exit 1; }
